//--- verilog/dma_pkg.sv
`default_nettype none

package dma_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   localparam int DATA_WIDTH      = 32;
   localparam int HOST_ADDR_WIDTH = 16;
   localparam int DDR_BANK_BITS   = 2;
   localparam int DDR_OFFSET_BITS = 8;
   localparam int DDR_ADDR_WIDTH  = DDR_BANK_BITS + DDR_OFFSET_BITS;
   localparam int LENGTH_WIDTH    = 8;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////

   typedef enum logic {
      HOST_TO_DDR = 1'b0,
      DDR_TO_HOST = 1'b1
   } t_dma_mode;

   // Local address, either one flat word address or a bank and an offset in it
   typedef union packed {
      logic [DDR_ADDR_WIDTH-1:0] flat;
      struct packed {
         logic [DDR_BANK_BITS-1:0]   bank;
         logic [DDR_OFFSET_BITS-1:0] offset;
      } fields;
   } t_ddr_addr;

   typedef struct packed {
      t_dma_mode                  mode;
      logic [HOST_ADDR_WIDTH-1:0] host_addr;
      t_ddr_addr                  ddr_addr;
      logic [LENGTH_WIDTH-1:0]    length;    // In words
   } t_dma_descriptor;

endpackage : dma_pkg

`default_nettype wire

//--- verilog/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if #(
   parameter int ADDR_WIDTH = dma_pkg::HOST_ADDR_WIDTH,
   parameter int DATA_WIDTH = dma_pkg::DATA_WIDTH
);

   logic                  req_valid;
   logic                  req_ready;
   logic                  req_write;
   logic [ADDR_WIDTH-1:0] req_addr;
   logic [DATA_WIDTH-1:0] req_wdata;

   logic                  rsp_valid;
   logic                  rsp_ready;
   logic [DATA_WIDTH-1:0] rsp_data;   // Only meaningful for reads

   // Side that issues requests
   modport source (
      output req_valid, req_write, req_addr, req_wdata, rsp_ready,
      input  req_ready, rsp_valid, rsp_data
   );

   // Side that answers them
   modport sink (
      input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
      output req_ready, rsp_valid, rsp_data
   );

endinterface : mem_if

`default_nettype wire

//--- verilog/dma_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     desc_req,
   input  dma_pkg::t_dma_descriptor desc,
   output logic                     desc_ack,
   output dma_pkg::t_dma_descriptor active_desc,
   mem_if.source                    host,
   mem_if.source                    ddr
);

   import dma_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      RD_REQ,
      RD_RSP,
      WR_REQ,
      WR_RSP,
      DONE
   } t_state;

   t_state                     state;
   t_dma_descriptor            desc_q;
   logic [HOST_ADDR_WIDTH-1:0] host_addr_q;
   t_ddr_addr                  ddr_addr_q;
   t_ddr_addr                  ddr_addr_next;
   logic [LENGTH_WIDTH-1:0]    words_left;
   logic [DATA_WIDTH-1:0]      data_q;

   logic                       read_phase;
   logic                       req_phase;
   logic                       rsp_phase;
   logic                       use_host;
   logic                       sel_req_ready;
   logic                       sel_rsp_valid;
   logic [DATA_WIDTH-1:0]      sel_rsp_data;

   ////////////////////////////////////////////////////////////
   // Port steering
   ////////////////////////////////////////////////////////////

   assign read_phase = (state == RD_REQ) || (state == RD_RSP);
   assign req_phase  = (state == RD_REQ) || (state == WR_REQ);
   assign rsp_phase  = (state == RD_RSP) || (state == WR_RSP);

   // Filling a bank reads the host, draining a bank writes it
   assign use_host = read_phase ? (desc_q.mode == HOST_TO_DDR) : (desc_q.mode == DDR_TO_HOST);

   assign sel_req_ready = use_host ? host.req_ready : ddr.req_ready;
   assign sel_rsp_valid = use_host ? host.rsp_valid : ddr.rsp_valid;
   assign sel_rsp_data  = use_host ? host.rsp_data  : ddr.rsp_data;

   assign host.req_valid = req_phase && use_host;
   assign host.req_write = (state == WR_REQ);
   assign host.req_addr  = host_addr_q;
   assign host.req_wdata = data_q;
   assign host.rsp_ready = rsp_phase && use_host;

   assign ddr.req_valid  = req_phase && !use_host;
   assign ddr.req_write  = (state == WR_REQ);
   assign ddr.req_addr   = ddr_addr_q;
   assign ddr.req_wdata  = data_q;
   assign ddr.rsp_ready  = rsp_phase && !use_host;

   assign desc_ack    = (state == DONE);
   assign active_desc = desc_q;

   always_comb begin
      ddr_addr_next      = ddr_addr_q;
      ddr_addr_next.flat = ddr_addr_q.flat + 1'b1;
      ddr_addr_next.fields.bank = desc_q.ddr_addr.fields.bank;   // Offset wraps in its bank
   end

   ////////////////////////////////////////////////////////////
   // Copy FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         words_left <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (desc_req) begin
                  words_left <= desc.length;
                  state      <= (desc.length == '0) ? DONE : RD_REQ;
               end
            end
            RD_REQ: if (sel_req_ready) state <= RD_RSP;
            RD_RSP: if (sel_rsp_valid) state <= WR_REQ;
            WR_REQ: if (sel_req_ready) state <= WR_RSP;
            WR_RSP: begin
               if (sel_rsp_valid) begin
                  words_left <= words_left - 1'b1;
                  state      <= (words_left == 8'd1) ? DONE : RD_REQ;
               end
            end
            DONE: if (!desc_req) state <= IDLE;   // Fourth phase of the handshake
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && desc_req) begin
         desc_q      <= desc;
         host_addr_q <= desc.host_addr;
         ddr_addr_q  <= desc.ddr_addr;
      end
      if (state == RD_RSP && sel_rsp_valid) begin
         data_q <= sel_rsp_data;
      end
      if (state == WR_RSP && sel_rsp_valid) begin
         host_addr_q <= host_addr_q + 1'b1;
         ddr_addr_q  <= ddr_addr_next;
      end
   end

   // No new local request while a bank is still answering the last one
   a_ddr_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      ddr.rsp_valid |-> !ddr.req_valid);

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(desc_ack) |-> desc_req);

endmodule : dma_ctrl

`default_nettype wire

//--- verilog/dma_ddr_selector.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ddr_selector #(
   parameter int NUM_BANKS = 4
)(
   input  dma_pkg::t_dma_descriptor descriptor,
   mem_if.sink                      selected_ddr_mem,
   mem_if.source                    ddr_mem[NUM_BANKS]
);

   import dma_pkg::*;

   logic [DDR_BANK_BITS-1:0] channel_select;
   logic [NUM_BANKS-1:0]     bank_hit;
   logic [NUM_BANKS-1:0]     bank_req_ready;
   logic [NUM_BANKS-1:0]     bank_rsp_valid;
   logic [DATA_WIDTH-1:0]    bank_rsp_data [NUM_BANKS];

   assign channel_select = descriptor.ddr_addr.fields.bank;

   genvar i;
   generate
      for (i = 0; i < NUM_BANKS; i++) begin : gen_bank
         assign bank_hit[i]       = (channel_select == DDR_BANK_BITS'(i));
         assign bank_req_ready[i] = ddr_mem[i].req_ready & bank_hit[i];
         assign bank_rsp_valid[i] = ddr_mem[i].rsp_valid;
         assign bank_rsp_data[i]  = ddr_mem[i].rsp_data & {DATA_WIDTH{ddr_mem[i].rsp_valid}};

         // Banks that are not selected see an idle port and drain freely
         always_comb begin
            ddr_mem[i].req_valid = 1'b0;
            ddr_mem[i].req_write = 1'b0;
            ddr_mem[i].req_addr  = '0;
            ddr_mem[i].req_wdata = '0;
            ddr_mem[i].rsp_ready = 1'b1;
            if (bank_hit[i]) begin
               ddr_mem[i].req_valid = selected_ddr_mem.req_valid;
               ddr_mem[i].req_write = selected_ddr_mem.req_write;
               ddr_mem[i].req_addr  = selected_ddr_mem.req_addr;
               ddr_mem[i].req_wdata = selected_ddr_mem.req_wdata;
               ddr_mem[i].rsp_ready = selected_ddr_mem.rsp_ready;
            end
         end
      end
   endgenerate

   ////////////////////////////////////////////////////////////
   // Merge back to the controller
   ////////////////////////////////////////////////////////////

   assign selected_ddr_mem.req_ready = |bank_req_ready;
   assign selected_ddr_mem.rsp_valid = |bank_rsp_valid;

   always_comb begin
      selected_ddr_mem.rsp_data = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         selected_ddr_mem.rsp_data = selected_ddr_mem.rsp_data | bank_rsp_data[b];
      end
   end

   // The OR merge is only sound with a single bank responding
   always_comb begin
      a_single_rsp: assert final ($isunknown(bank_rsp_valid) || $onehot0(bank_rsp_valid))
         else $error("Several banks respond at once");
   end

endmodule : dma_ddr_selector

`default_nettype wire

//--- verilog/ddr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_bank #(
   parameter int BANK_DEPTH = 256
)(
   input  logic clk,
   input  logic rst_n,
   mem_if.sink  mem
);

   import dma_pkg::*;

   localparam int IDX_WIDTH = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

   logic [DATA_WIDTH-1:0] ram [BANK_DEPTH];
   t_ddr_addr             req_addr_view;
   logic [IDX_WIDTH-1:0]  req_idx;
   logic                  req_fire;
   logic                  rsp_pending;
   logic                  rsp_is_read;
   logic [DATA_WIDTH-1:0] rsp_data_q;

   assign req_addr_view = mem.req_addr;
   assign req_idx       = req_addr_view.fields.offset[IDX_WIDTH-1:0];   // Bank bits ignored here
   assign req_fire      = mem.req_valid && mem.req_ready;

   assign mem.req_ready = !rsp_pending;
   assign mem.rsp_valid = rsp_pending;
   assign mem.rsp_data  = rsp_data_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_pending <= 1'b0;
      end else if (req_fire) begin
         rsp_pending <= 1'b1;
      end else if (mem.rsp_ready) begin
         rsp_pending <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         rsp_is_read <= !mem.req_write;
         if (mem.req_write) begin
            ram[req_idx] <= mem.req_wdata;
         end else begin
            rsp_data_q <= ram[req_idx];
         end
      end
   end

   a_read_data_known: assert property (@(posedge clk) disable iff (!rst_n)
      (mem.rsp_valid && rsp_is_read) |-> !$isunknown(mem.rsp_data));

endmodule : ddr_bank

`default_nettype wire

//--- verilog/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top #(
   parameter int NUM_BANKS  = 4,
   parameter int BANK_DEPTH = 256
)(
   input  logic                                clk,
   input  logic                                rst_n,

   input  logic                                desc_req,
   input  dma_pkg::t_dma_mode                  desc_mode,
   input  logic [dma_pkg::HOST_ADDR_WIDTH-1:0] desc_host_addr,
   input  logic [dma_pkg::DDR_ADDR_WIDTH-1:0]  desc_ddr_addr,
   input  logic [dma_pkg::LENGTH_WIDTH-1:0]    desc_length,
   output logic                                desc_ack,

   output logic                                host_req_valid,
   input  logic                                host_req_ready,
   output logic                                host_req_write,
   output logic [dma_pkg::HOST_ADDR_WIDTH-1:0] host_req_addr,
   output logic [dma_pkg::DATA_WIDTH-1:0]      host_req_wdata,
   input  logic                                host_rsp_valid,
   output logic                                host_rsp_ready,
   input  logic [dma_pkg::DATA_WIDTH-1:0]      host_rsp_data
);

   import dma_pkg::*;

   t_dma_descriptor desc;
   t_dma_descriptor active_desc;

   mem_if #(.ADDR_WIDTH(HOST_ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) host_bus ();
   mem_if #(.ADDR_WIDTH(DDR_ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) ctrl_ddr ();
   mem_if #(.ADDR_WIDTH(DDR_ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) bank_if [NUM_BANKS] ();

   assign desc.mode          = desc_mode;
   assign desc.host_addr     = desc_host_addr;
   assign desc.ddr_addr.flat = desc_ddr_addr;
   assign desc.length        = desc_length;

   ////////////////////////////////////////////////////////////
   // Host side as plain ports
   ////////////////////////////////////////////////////////////

   assign host_req_valid     = host_bus.req_valid;
   assign host_req_write     = host_bus.req_write;
   assign host_req_addr      = host_bus.req_addr;
   assign host_req_wdata     = host_bus.req_wdata;
   assign host_rsp_ready     = host_bus.rsp_ready;
   assign host_bus.req_ready = host_req_ready;
   assign host_bus.rsp_valid = host_rsp_valid;
   assign host_bus.rsp_data  = host_rsp_data;

   dma_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .desc_req    (desc_req),
      .desc        (desc),
      .desc_ack    (desc_ack),
      .active_desc (active_desc),
      .host        (host_bus),
      .ddr         (ctrl_ddr)
   );

   dma_ddr_selector #(.NUM_BANKS(NUM_BANKS)) u_selector (
      .descriptor       (active_desc),
      .selected_ddr_mem (ctrl_ddr),
      .ddr_mem          (bank_if)
   );

   genvar g;
   generate
      for (g = 0; g < NUM_BANKS; g++) begin : gen_banks
         ddr_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .mem   (bank_if[g])
         );
      end
   endgenerate

endmodule : dma_top

`default_nettype wire

//--- dv/tb_host_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_mem (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                req_valid,
   output logic                                req_ready,
   input  logic                                req_write,
   input  logic [dma_pkg::HOST_ADDR_WIDTH-1:0] req_addr,
   input  logic [dma_pkg::DATA_WIDTH-1:0]      req_wdata,
   output logic                                rsp_valid,
   input  logic                                rsp_ready,
   output logic [dma_pkg::DATA_WIDTH-1:0]      rsp_data
);

   import dma_pkg::*;

   logic [DATA_WIDTH-1:0]      mem [1<<HOST_ADDR_WIDTH];
   logic [HOST_ADDR_WIDTH-1:0] addr_q;
   logic                       pending;

   initial begin
      req_ready = 1'b0;
      rsp_valid = 1'b0;
      rsp_data  = '0;
      for (int a = 0; a < (1 << HOST_ADDR_WIDTH); a++) begin
         mem[a] = DATA_WIDTH'(a) ^ 32'hA5A50000;
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= 1'b0;
         addr_q  <= '0;
      end else if (req_valid && req_ready) begin
         pending <= 1'b1;
         addr_q  <= req_addr;
         if (req_write) begin
            mem[req_addr] <= req_wdata;
         end
      end else if (rsp_valid && rsp_ready) begin
         pending <= 1'b0;
      end
   end

   // Random stalls where a raised response stays up until it is taken
   always @(negedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_ready <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_data  <= '0;
      end else begin
         req_ready <= !pending && (($urandom % 4) != 0);
         rsp_valid <= pending && (rsp_valid || (($urandom % 3) != 0));
         rsp_data  <= mem[addr_q];   // Stable while a response is pending
      end
   end

endmodule : tb_host_mem

`default_nettype wire

//--- dv/tb_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_top;

   import dma_pkg::*;

   localparam int NUM_BANKS   = 4;
   localparam int BANK_DEPTH  = 256;
   localparam int MAX_DESC    = 32;
   localparam int ACK_TIMEOUT = 4000;
   localparam int HOST_WORDS  = 1 << HOST_ADDR_WIDTH;

   logic                       clk;
   logic                       rst_n;
   logic                       desc_req;
   t_dma_mode                  desc_mode;
   logic [HOST_ADDR_WIDTH-1:0] desc_host_addr;
   logic [DDR_ADDR_WIDTH-1:0]  desc_ddr_addr;
   logic [LENGTH_WIDTH-1:0]    desc_length;
   logic                       desc_ack;
   logic                       host_req_valid;
   logic                       host_req_ready;
   logic                       host_req_write;
   logic [HOST_ADDR_WIDTH-1:0] host_req_addr;
   logic [DATA_WIDTH-1:0]      host_req_wdata;
   logic                       host_rsp_valid;
   logic                       host_rsp_ready;
   logic [DATA_WIDTH-1:0]      host_rsp_data;

   logic [31:0]           golden [5*MAX_DESC];
   logic [DATA_WIDTH-1:0] host_model [HOST_WORDS];
   logic [DATA_WIDTH-1:0] ddr_model [1<<DDR_ADDR_WIDTH];
   int                    host_req_count;
   int                    outstanding;
   int                    errors;

   dma_top #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) DUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .desc_req       (desc_req),
      .desc_mode      (desc_mode),
      .desc_host_addr (desc_host_addr),
      .desc_ddr_addr  (desc_ddr_addr),
      .desc_length    (desc_length),
      .desc_ack       (desc_ack),
      .host_req_valid (host_req_valid),
      .host_req_ready (host_req_ready),
      .host_req_write (host_req_write),
      .host_req_addr  (host_req_addr),
      .host_req_wdata (host_req_wdata),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp_ready (host_rsp_ready),
      .host_rsp_data  (host_rsp_data)
   );

   tb_host_mem u_host_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (host_req_valid),
      .req_ready (host_req_ready),
      .req_write (host_req_write),
      .req_addr  (host_req_addr),
      .req_wdata (host_req_wdata),
      .rsp_valid (host_rsp_valid),
      .rsp_ready (host_rsp_ready),
      .rsp_data  (host_rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Failure handling and reference model
   ////////////////////////////////////////////////////////////

   task automatic end_in_failure();
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("FAILED at %0t ns: %s", $time, msg);
      end_in_failure();
   endtask

   // Word i of a transfer stays in the starting bank, its offset wraps at 256
   function automatic int ddr_index(input int start, input int i);
      return (start / 256) * 256 + (start + i) % 256;
   endfunction

   task automatic wait_for_ack(input logic level, output int cycles);
      cycles = 0;
      while (desc_ack !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > ACK_TIMEOUT) begin
            $display("Timed out waiting for desc_ack to become %0b", level);
            end_in_failure();
         end
      end
   endtask

   task automatic check_host_range(input int host, input int len);
      int addr;
      for (int i = 0; i < len; i++) begin
         addr = (host + i) % HOST_WORDS;
         assert (u_host_mem.mem[addr] === host_model[addr])
            else report_failure($sformatf("host word %h is %h, expected %h",
                                          addr, u_host_mem.mem[addr], host_model[addr]));
      end
   endtask

   task automatic run_descriptor(input int row);
      t_dma_mode mode;
      int        host;
      int        ddr;
      int        len;
      int        tag;
      int        requests_before;
      int        cycles;
      mode = t_dma_mode'(golden[5*row][0]);
      host = golden[5*row+1];
      ddr  = golden[5*row+2];
      len  = golden[5*row+3];
      tag  = golden[5*row+4];
      requests_before = host_req_count;
      @(negedge clk);
      assert (desc_ack === 1'b0) else report_failure("desc_ack high before desc_req");
      desc_mode      = mode;
      desc_host_addr = HOST_ADDR_WIDTH'(host);
      desc_ddr_addr  = DDR_ADDR_WIDTH'(ddr);
      desc_length    = LENGTH_WIDTH'(len);
      desc_req       = 1'b1;
      wait_for_ack(1'b1, cycles);
      if (tag == 2) begin
         assert (cycles == 1)
            else report_failure($sformatf("zero length ack after %0d cycles", cycles));
      end
      @(negedge clk);
      assert (desc_ack === 1'b1) else report_failure("desc_ack dropped while desc_req high");
      desc_req = 1'b0;
      wait_for_ack(1'b0, cycles);
      assert (host_req_count - requests_before == len)
         else report_failure($sformatf("row %0d made %0d host requests, expected %0d",
                                       row, host_req_count - requests_before, len));
      for (int i = 0; i < len; i++) begin
         if (mode == HOST_TO_DDR) begin
            ddr_model[ddr_index(ddr, i)] = host_model[(host + i) % HOST_WORDS];
         end else begin
            host_model[(host + i) % HOST_WORDS] = ddr_model[ddr_index(ddr, i)];
         end
      end
      if (tag == 1) begin
         check_host_range(host, len);
      end
   endtask

   // Host port monitor, one outstanding request at most
   always @(posedge clk) begin
      if (rst_n) begin
         assert (!(host_req_valid && outstanding != 0))
            else report_failure("host request issued while one is outstanding");
         if (host_req_valid && host_req_ready) begin
            outstanding++;
            host_req_count++;
         end
         if (host_rsp_valid && host_rsp_ready) outstanding--;
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int row;
      void'($urandom(57));
      errors         = 0;
      host_req_count = 0;
      outstanding    = 0;
      rst_n          = 1'b0;
      desc_req       = 1'b0;
      desc_mode      = HOST_TO_DDR;
      desc_host_addr = '0;
      desc_ddr_addr  = '0;
      desc_length    = '0;
      for (int a = 0; a < HOST_WORDS; a++) begin
         host_model[a] = DATA_WIDTH'(a) ^ 32'hA5A50000;
      end
      $readmemh("dv/dma_golden.txt", golden);
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      repeat (20) begin   // Idle with no descriptor
         @(negedge clk);
         assert (desc_ack === 1'b0 && host_req_valid === 1'b0)
            else report_failure("DUT active without a descriptor");
      end
      assert (host_req_count == 0) else report_failure("host request seen while idle");

      row = 0;
      while (row < MAX_DESC && golden[5*row+4] != 32'hFF) begin
         run_descriptor(row);
         row++;
      end
      assert (row > 0) else report_failure("golden file holds no descriptors");

      if (errors == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         end_in_failure();
      end
   end

endmodule : tb_dma_top

`default_nettype wire

//--- list.f
verilog/dma_pkg.sv
verilog/mem_if.sv
verilog/dma_ctrl.sv
verilog/dma_ddr_selector.sv
verilog/ddr_bank.sv
verilog/dma_top.sv
dv/tb_host_mem.sv
dv/tb_dma_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/dma_golden.txt
// mode host_addr ddr_addr(bank,offset) length tag
// tag 00 fill only, 01 check host words written, 02 zero length, FF end of table
0 0100 010 10 00
1 0800 010 10 01
0 0200 020 08 00
0 0300 120 08 00
1 0900 020 08 01
1 0A00 120 08 01
0 0400 2FE 04 00
1 0B00 2FE 04 01
1 0C00 200 02 01
0 0500 030 00 02
1 0D00 030 00 02
0 1000 3C0 20 00
1 1100 3C0 20 01
0 0000 000 00 FF
